// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= exe_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+tb
verilog/exe_pkg.sv
verilog/muldiv_unit.sv
verilog/alu.sv
verilog/branch_resolve.sv
verilog/store_format.sv
verilog/exe_stage.sv
tb/exe_tb.sv

// File: tb/exe_ref_model.svh
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

function automatic logic is_muldiv(alu_op_e op);
    return op inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
endfunction

function automatic logic is_load(mem_op_e op);
    return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
endfunction

function automatic es_to_ms_t expected_ms(ds_to_es_t d);
    es_to_ms_t          m;
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        wide;
    logic               ov;
    logic               ades;
    logic               adel;
    int                 ofs;
    a  = d.src1_sel ? d.src1_alt : d.rs_value;
    b  = d.src2_sel ? d.src2_alt : d.rt_value;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'h0, a};
    ub = {32'h0, b};
    m  = '0;
    ov = 1'b0;
    case (d.alu_op)
        ALU_ADD, ALU_ADDU: begin
            wide     = sa + sb;
            m.result = wide[31:0];
            ov       = (d.alu_op == ALU_ADD) && (wide[32] != wide[31]);  // exact sum fits?
        end
        ALU_SUB, ALU_SUBU: begin
            wide     = sa - sb;
            m.result = wide[31:0];
            ov       = (d.alu_op == ALU_SUB) && (wide[32] != wide[31]);
        end
        ALU_SLT:   m.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU:  m.result = (a < b) ? 32'd1 : 32'd0;
        ALU_AND:   m.result = a & b;
        ALU_OR:    m.result = a | b;
        ALU_XOR:   m.result = a ^ b;
        ALU_NOR:   m.result = ~(a | b);
        ALU_SLL:   m.result = b << a[4:0];
        ALU_SRL:   m.result = b >> a[4:0];
        ALU_SRA:   m.result = 32'($signed(b) >>> a[4:0]);
        ALU_LUI:   m.result = {b[15:0], 16'h0};
        ALU_MULT:  {m.hi, m.lo} = 64'(sa * sb);
        ALU_MULTU: {m.hi, m.lo} = ua * ub;
        ALU_DIV: begin
            m.lo = 32'(sa / sb);   // 64-bit math keeps min / -1 defined
            m.hi = 32'(sa % sb);
        end
        ALU_DIVU: begin
            m.lo = 32'(ua / ub);
            m.hi = 32'(ua % ub);
        end
        default: m.result = '0;
    endcase
    ofs     = int'(m.result[1:0]);
    m.wdata = d.rt_value;
    m.wen   = 4'b0000;
    case (d.mem_op)
        MEM_SB: begin
            m.wdata = {4{d.rt_value[7:0]}};
            m.wen   = 4'b0001 << ofs;
        end
        MEM_SH: begin
            m.wdata = {2{d.rt_value[15:0]}};
            m.wen   = (ofs >= 2) ? 4'b1100 : 4'b0011;
        end
        MEM_SW: m.wen = 4'b1111;
        MEM_SWL, MEM_SWR: begin
            m.wdata = '0;
            for (int i = 0; i < 4; i++) begin
                if (d.mem_op == MEM_SWL && i <= ofs) begin   // top bytes of rt
                    m.wen[i]            = 1'b1;
                    m.wdata[8*i +: 8]   = d.rt_value[8*(i+3-ofs) +: 8];
                end else if (d.mem_op == MEM_SWR && i >= ofs) begin
                    m.wen[i]            = 1'b1;
                    m.wdata[8*i +: 8]   = d.rt_value[8*(i-ofs) +: 8];
                end
            end
        end
        default: m.wen = 4'b0000;
    endcase
    ades = (d.mem_op == MEM_SH && ofs % 2 != 0) || (d.mem_op == MEM_SW && ofs != 0);
    adel = ((d.mem_op == MEM_LH || d.mem_op == MEM_LHU) && ofs % 2 != 0) ||
           (d.mem_op == MEM_LW && ofs != 0);
    m.ex       = d.in_ex || ov || ades || adel;
    m.exc_code = d.in_ex ? d.in_exc_code : ov ? 5'd12 : ades ? 5'd5 : adel ? 5'd4 : 5'd0;
    m.pc       = d.pc;
    m.mem_op   = d.mem_op;
    m.mem_we   = (m.wen != 4'b0000) && !m.ex;
    m.gr_we    = d.gr_we;
    m.dest     = d.dest;
    m.bd       = d.bd;
    return m;
endfunction

function automatic br_bus_t expected_br(ds_to_es_t d);
    br_bus_t     r;
    logic [31:0] npc;
    npc         = d.pc + 32'd4;
    r.valid     = 1'b1;
    r.pc        = d.pc;
    r.is_branch = (d.br_op != BR_NONE);
    case (d.br_op)
        BR_BEQ:              r.taken = (d.rs_value == d.rt_value);
        BR_BNE:              r.taken = (d.rs_value != d.rt_value);
        BR_BGEZ, BR_BGEZAL:  r.taken = ($signed(d.rs_value) >= 0);
        BR_BGTZ:             r.taken = ($signed(d.rs_value) > 0);
        BR_BLEZ:             r.taken = ($signed(d.rs_value) <= 0);
        BR_BLTZ, BR_BLTZAL:  r.taken = ($signed(d.rs_value) < 0);
        BR_J, BR_JAL, BR_JR, BR_JALR: r.taken = 1'b1;
        default:             r.taken = 1'b0;
    endcase
    case (d.br_op)
        BR_JR, BR_JALR: r.target = d.rs_value;
        BR_J, BR_JAL:   r.target = {npc[31:28], d.jidx, 2'b00};
        default:        r.target = d.imm_br_target;
    endcase
    // right means same direction, and same target when taken
    r.predict_right = r.taken ? (d.bpu_taken && d.bpu_target == r.target) : !d.bpu_taken;
    return r;
endfunction

function automatic logic expected_br_flush(ds_to_es_t d);
    br_bus_t r;
    r = expected_br(d);
    return d.bpu_valid ? (r.is_branch && !r.predict_right) : r.taken;
endfunction

`endif

// File: tb/exe_tb.sv
`timescale 1ns/1ps

module exe_tb;
    import exe_pkg::*;

    `include "exe_ref_model.svh"

    localparam int NUM_RECORDS = 600;
    localparam int MAX_CYCLES  = 40000;

    logic            clk;
    logic            reset;
    logic            flush;
    logic            ds_to_es_valid;
    ds_to_es_t       ds_to_es_bus;
    logic            es_allowin;
    logic            ms_allowin;
    logic            es_to_ms_valid;
    es_to_ms_t       es_to_ms_bus;
    br_bus_t         br_bus;
    logic            br_flush;
    logic [4:0]      exe_dest;
    logic [XLEN-1:0] exe_result;
    logic            exe_load;

    ds_to_es_t held_q[$];      // record the stage should hold, at most one
    int        held_age;       // edges since that record was accepted
    int        error_count   = 0;
    int        timeout_count = 0;
    int        done_count    = 0;
    int        flushed_count = 0;
    int        cycles;
    logic      stop_run = 1'b0;

    exe_stage UUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .br_bus         (br_bus),
        .br_flush       (br_flush),
        .exe_dest       (exe_dest),
        .exe_result     (exe_result),
        .exe_load       (exe_load)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic ds_to_es_t random_record();
        ds_to_es_t d;
        d.pc            = $urandom & 32'hffff_fffc;
        d.alu_op        = alu_op_e'(5'($urandom % 18));
        d.rs_value      = $urandom;
        d.rt_value      = (($urandom % 8) == 0) ? d.rs_value : $urandom;  // some equal pairs
        d.src1_sel      = 1'($urandom);
        d.src1_alt      = $urandom % 32;
        d.src2_sel      = 1'($urandom);
        d.src2_alt      = $urandom;
        d.imm_br_target = $urandom & 32'hffff_fffc;
        d.jidx          = 26'($urandom);
        d.br_op         = (($urandom % 2) == 0) ? BR_NONE : br_op_e'(4'($urandom % 13));
        d.mem_op        = (($urandom % 2) == 0) ? MEM_NONE : mem_op_e'(4'($urandom % 11));
        d.gr_we         = 1'($urandom);
        d.dest          = 5'($urandom);
        d.bpu_valid     = 1'($urandom);
        d.bpu_taken     = 1'($urandom);
        d.bpu_target    = (($urandom % 2) == 0) ? d.imm_br_target : d.rs_value;
        d.in_ex         = (($urandom % 16) == 0);
        d.in_exc_code   = 5'($urandom);
        d.bd            = 1'($urandom);
        if (d.mem_op != MEM_NONE) begin   // base plus small offset
            d.alu_op   = ALU_ADDU;
            d.src1_sel = 1'b0;
            d.src2_sel = 1'b1;
            d.src2_alt = $urandom % 16;
        end
        if (d.alu_op inside {ALU_DIV, ALU_DIVU}) begin
            d.src2_sel = 1'b0;
            if (d.rt_value == '0) d.rt_value = 32'd7;
        end
        return d;
    endfunction

    task automatic compare_ms(input es_to_ms_t got, input es_to_ms_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR es_to_ms_bus at %0t: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_br(input br_bus_t got, input br_bus_t exp,
                              input logic got_flush, input logic exp_flush);
        if (got !== exp) begin
            error_count++;
            $display("ERROR br_bus at %0t: got %h expected %h", $time, got, exp);
        end
        if (got_flush !== exp_flush) begin
            error_count++;
            $display("ERROR br_flush at %0t: got %h expected %h", $time, got_flush, exp_flush);
        end
    endtask

    task automatic compare_bypass(input logic [4:0] got_dest, input logic [XLEN-1:0] got_result,
                                  input logic got_load, input logic [4:0] exp_dest,
                                  input logic [XLEN-1:0] exp_result, input logic exp_load);
        if (got_dest !== exp_dest || got_result !== exp_result || got_load !== exp_load) begin
            error_count++;
            $display("ERROR exe_dest/exe_result/exe_load at %0t: got %h %h %h expected %h %h %h",
                     $time, got_dest, got_result, got_load, exp_dest, exp_result, exp_load);
        end
    endtask

    task automatic check_outputs();
        ds_to_es_t d;
        es_to_ms_t exp_ms;
        int        latency;
        if (held_q.size() == 0) begin
            if (es_to_ms_valid || !es_allowin || br_bus.valid || br_flush) begin
                error_count++;
                $display("at %0t: stage is empty but valid, allowin or branch outputs are wrong",
                         $time);
            end
            compare_bypass(exe_dest, exe_result, exe_load, 5'd0, '0, 1'b0);
        end else begin
            d      = held_q[0];
            exp_ms = expected_ms(d);
            compare_br(br_bus, expected_br(d), br_flush, expected_br_flush(d));
            compare_bypass(exe_dest, exe_result, exe_load, d.gr_we ? d.dest : 5'd0,
                           exp_ms.result, is_load(d.mem_op));
            if (es_to_ms_valid) begin
                compare_ms(es_to_ms_bus, exp_ms);   // every cycle, so a stall must hold it
                if (es_allowin !== ms_allowin) begin
                    error_count++;
                    $display("at %0t: es_allowin does not follow ms_allowin", $time);
                end
            end
            if (is_muldiv(d.alu_op)) begin
                // result shows up latency cycles after the accepting edge
                latency = (d.alu_op inside {ALU_MULT, ALU_MULTU}) ? MUL_CYCLES : DIV_CYCLES;
                if (es_to_ms_valid && held_age <= latency) begin
                    error_count++;
                    $display("at %0t: mul/div result came after %0d of %0d cycles",
                             $time, held_age - 1, latency);
                end
                if (!es_to_ms_valid && es_allowin) begin
                    error_count++;
                    $display("at %0t: stage would accept a record while mul/div is busy", $time);
                end
                if (!es_to_ms_valid && held_age > latency) begin
                    timeout_count++;
                    stop_run = 1'b1;
                    $display("at %0t: mul/div result still missing after %0d cycles",
                             $time, held_age - 1);
                end
            end else if (!es_to_ms_valid) begin
                error_count++;
                $display("at %0t: single-cycle record is held but not passed on", $time);
            end
        end
    endtask

    // what the coming edge does to the held record
    task automatic update_model();
        if (flush) begin
            if (held_q.size() > 0) begin
                void'(held_q.pop_front());
                flushed_count++;
            end
        end else begin
            if (es_to_ms_valid && ms_allowin && held_q.size() > 0) begin
                void'(held_q.pop_front());
                done_count++;
            end
            if (ds_to_es_valid && es_allowin) begin
                held_q.push_back(ds_to_es_bus);
                held_age = 0;
            end
        end
        held_age++;
    endtask

    task automatic run_cycle(input logic random_inputs);
        @(negedge clk);
        if (random_inputs) begin
            ds_to_es_valid = (($urandom % 4) != 0);
            ds_to_es_bus   = random_record();
            ms_allowin     = (($urandom % 4) != 0);
            flush          = (($urandom % 64) == 0);   // rare
        end else begin
            ds_to_es_valid = 1'b0;
            ms_allowin     = 1'b1;
            flush          = 1'b0;
        end
        #1;
        check_outputs();
        update_model();
    endtask

    initial begin
        void'($urandom(32'hd5c4));
        reset          = 1'b1;
        flush          = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        ms_allowin     = 1'b0;
        held_age       = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (done_count < NUM_RECORDS && !stop_run) begin
            run_cycle(1'b1);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                timeout_count++;
                stop_run = 1'b1;
                $display("random run timed out with %0d records done", done_count);
            end
        end

        // drain, then a few idle cycles with the stage empty
        cycles = 0;
        while (held_q.size() > 0 && !stop_run) begin
            run_cycle(1'b0);
            cycles++;
            if (cycles > DIV_CYCLES + 4) begin
                timeout_count++;
                stop_run = 1'b1;
                $display("last record never left the stage");
            end
        end
        repeat (3) run_cycle(1'b0);

        $display("records done %0d, flushed %0d, errors %0d, timeouts %0d",
                 done_count, flushed_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     kill,
    input  logic                     start,
    input  exe_pkg::alu_op_e         alu_op,
    input  logic [exe_pkg::XLEN-1:0] src1,
    input  logic [exe_pkg::XLEN-1:0] src2,
    output logic [exe_pkg::XLEN-1:0] result,
    output logic [exe_pkg::XLEN-1:0] hi,
    output logic [exe_pkg::XLEN-1:0] lo,
    output logic                     overflow,
    output logic                     busy,
    output logic                     done
);
    import exe_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [4:0]      sa;
    logic            is_md;
    logic            md_start;
    logic            busy_r;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign sa   = src1[4:0];     // shift amount rides on src1

    assign is_md    = alu_op inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
    assign md_start = start && is_md;

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src2 << sa;
            ALU_SRL:  result = src2 >> sa;
            ALU_SRA:  result = XLEN'($signed(src2) >>> sa);
            ALU_LUI:  result = {src2[15:0], 16'b0};
            default:  result = '0;   // mul/div results leave on hi/lo
        endcase
    end

    // signed overflow, only the trapping forms
    always_comb begin
        case (alu_op)
            ALU_ADD: overflow = (src1[XLEN-1] == src2[XLEN-1]) &&
                                (sum[XLEN-1] != src1[XLEN-1]);
            ALU_SUB: overflow = (src1[XLEN-1] != src2[XLEN-1]) &&
                                (diff[XLEN-1] != src1[XLEN-1]);
            default: overflow = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            busy_r <= 1'b0;
        end else if (md_start) begin
            busy_r <= 1'b1;
        end else if (done) begin
            busy_r <= 1'b0;
        end
    end

    assign busy = busy_r && !done;

    muldiv_unit u_muldiv_unit (
        .clk   (clk),
        .reset (reset),
        .kill  (kill),
        .start (md_start),
        .op    (alu_op),
        .a     (src1),
        .b     (src2),
        .hi    (hi),
        .lo    (lo),
        .done  (done)
    );

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic                     valid,
    input  exe_pkg::br_op_e          br_op,
    input  logic [exe_pkg::XLEN-1:0] rs_value,
    input  logic [exe_pkg::XLEN-1:0] rt_value,
    input  logic [exe_pkg::XLEN-1:0] pc,
    input  logic [exe_pkg::XLEN-1:0] imm_br_target,
    input  logic [25:0]              jidx,
    input  logic                     bpu_valid,
    input  logic                     bpu_taken,
    input  logic [exe_pkg::XLEN-1:0] bpu_target,
    output exe_pkg::br_bus_t         br_bus,
    output logic                     br_flush
);
    import exe_pkg::*;

    logic            rs_eq_rt;
    logic            rs_ltz;
    logic            rs_lez;
    logic            is_branch;
    logic            taken;
    logic            predict_right;
    logic [XLEN-1:0] slot_pc;
    logic [XLEN-1:0] target;

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ltz   = rs_value[XLEN-1];
    assign rs_lez   = rs_ltz || (rs_value == '0);
    assign slot_pc  = pc + XLEN'(4);    // jump region comes from the delay slot

    always_comb begin
        case (br_op)
            BR_BEQ:                       taken = rs_eq_rt;
            BR_BNE:                       taken = !rs_eq_rt;
            BR_BGEZ, BR_BGEZAL:           taken = !rs_ltz;
            BR_BGTZ:                      taken = !rs_lez;
            BR_BLEZ:                      taken = rs_lez;
            BR_BLTZ, BR_BLTZAL:           taken = rs_ltz;
            BR_J, BR_JAL, BR_JR, BR_JALR: taken = 1'b1;
            default:                      taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_op)
            BR_JR, BR_JALR: target = rs_value;
            BR_J, BR_JAL:   target = {slot_pc[XLEN-1:XLEN-4], jidx, 2'b00};
            default:        target = imm_br_target;
        endcase
    end

    assign is_branch     = (br_op != BR_NONE);
    assign predict_right = taken ? (bpu_taken && target == bpu_target) : !bpu_taken;

    // unpredicted items only redirect when taken
    assign br_flush = valid && (bpu_valid ? (is_branch && !predict_right) : taken);

    always_comb begin
        br_bus.valid         = valid;
        br_bus.is_branch     = is_branch;
        br_bus.taken         = taken;
        br_bus.predict_right = predict_right;
        br_bus.target        = target;
        br_bus.pc            = pc;
    end

endmodule

// File: verilog/exe_pkg.sv
package exe_pkg;

    localparam int XLEN       = 32;
    localparam int MUL_CYCLES = 2;   // operand latch, then product
    localparam int DIV_CYCLES = 33;  // operand latch, then 32 steps

    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
        MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_BGEZAL, BR_BLTZAL, BR_J, BR_JAL, BR_JR, BR_JALR
    } br_op_e;

    // codes raised here; decode codes pass through as raw values
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        alu_op_e         alu_op;
        logic [XLEN-1:0] rs_value;
        logic [XLEN-1:0] rt_value;
        logic            src1_sel;       // use src1_alt instead of rs
        logic [XLEN-1:0] src1_alt;       // shift amount or link pc
        logic            src2_sel;       // use src2_alt instead of rt
        logic [XLEN-1:0] src2_alt;       // extended immediate
        logic [XLEN-1:0] imm_br_target;
        logic [25:0]     jidx;
        br_op_e          br_op;
        mem_op_e         mem_op;
        logic            gr_we;
        logic [4:0]      dest;
        logic            bpu_valid;
        logic            bpu_taken;
        logic [XLEN-1:0] bpu_target;
        logic            in_ex;
        logic [4:0]      in_exc_code;
        logic            bd;
    } ds_to_es_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] result;         // alu value or memory address
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
        mem_op_e         mem_op;
        logic            mem_we;
        logic [3:0]      wen;
        logic [XLEN-1:0] wdata;
        logic            gr_we;
        logic [4:0]      dest;
        logic            ex;
        logic [4:0]      exc_code;
        logic            bd;
    } es_to_ms_t;

    typedef struct packed {
        logic            valid;
        logic            is_branch;
        logic            taken;
        logic            predict_right;
        logic [XLEN-1:0] target;
        logic [XLEN-1:0] pc;
    } br_bus_t;

endpackage

// File: verilog/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     ds_to_es_valid,
    input  exe_pkg::ds_to_es_t       ds_to_es_bus,
    output logic                     es_allowin,
    input  logic                     ms_allowin,
    output logic                     es_to_ms_valid,
    output exe_pkg::es_to_ms_t       es_to_ms_bus,
    output exe_pkg::br_bus_t         br_bus,
    output logic                     br_flush,
    output logic [4:0]               exe_dest,
    output logic [exe_pkg::XLEN-1:0] exe_result,
    output logic                     exe_load
);
    import exe_pkg::*;

    logic            es_valid;
    logic            es_ready_go;
    logic            accept;
    ds_to_es_t       ds_r;
    logic            es_is_md;
    logic            md_start;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_hi;
    logic [XLEN-1:0] alu_lo;
    logic            alu_overflow;
    logic            alu_busy;
    logic            alu_done;
    logic [3:0]      sf_wen;
    logic [XLEN-1:0] sf_wdata;
    logic            sf_ades;
    logic            sf_adel;
    logic            es_ex;
    logic [4:0]      es_exc_code;

    assign accept = ds_to_es_valid && es_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_r <= '0;
        end else if (accept) begin
            ds_r <= ds_to_es_bus;
        end
    end

    assign es_is_md = ds_r.alu_op inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
    // first cycle of a mul/div item: unit idle and no result yet
    assign md_start    = es_valid && es_is_md && !alu_busy && !alu_done;
    assign es_ready_go = !es_is_md || alu_done;

    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    assign src1 = ds_r.src1_sel ? ds_r.src1_alt : ds_r.rs_value;
    assign src2 = ds_r.src2_sel ? ds_r.src2_alt : ds_r.rt_value;

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .kill     (flush || accept),   // new item drops the old result
        .start    (md_start),
        .alu_op   (ds_r.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .hi       (alu_hi),
        .lo       (alu_lo),
        .overflow (alu_overflow),
        .busy     (alu_busy),
        .done     (alu_done)
    );

    branch_resolve u_branch_resolve (
        .valid         (es_valid),
        .br_op         (ds_r.br_op),
        .rs_value      (ds_r.rs_value),
        .rt_value      (ds_r.rt_value),
        .pc            (ds_r.pc),
        .imm_br_target (ds_r.imm_br_target),
        .jidx          (ds_r.jidx),
        .bpu_valid     (ds_r.bpu_valid),
        .bpu_taken     (ds_r.bpu_taken),
        .bpu_target    (ds_r.bpu_target),
        .br_bus        (br_bus),
        .br_flush      (br_flush)
    );

    store_format u_store_format (
        .mem_op   (ds_r.mem_op),
        .addr     (alu_result),
        .rt_value (ds_r.rt_value),
        .wen      (sf_wen),
        .wdata    (sf_wdata),
        .ades     (sf_ades),
        .adel     (sf_adel)
    );

    // decode exception first, then ov, ades, adel
    always_comb begin
        es_ex = 1'b1;
        if (ds_r.in_ex) begin
            es_exc_code = ds_r.in_exc_code;
        end else if (alu_overflow) begin
            es_exc_code = EXC_OV;
        end else if (sf_ades) begin
            es_exc_code = EXC_ADES;
        end else if (sf_adel) begin
            es_exc_code = EXC_ADEL;
        end else begin
            es_ex       = 1'b0;
            es_exc_code = EXC_NONE;
        end
    end

    always_comb begin
        es_to_ms_bus.pc       = ds_r.pc;
        es_to_ms_bus.result   = alu_result;
        es_to_ms_bus.hi       = es_is_md ? alu_hi : '0;
        es_to_ms_bus.lo       = es_is_md ? alu_lo : '0;
        es_to_ms_bus.mem_op   = ds_r.mem_op;
        es_to_ms_bus.mem_we   = (|sf_wen) && !es_ex;  // faulting store never writes
        es_to_ms_bus.wen      = sf_wen;
        es_to_ms_bus.wdata    = sf_wdata;
        es_to_ms_bus.gr_we    = ds_r.gr_we;
        es_to_ms_bus.dest     = ds_r.dest;
        es_to_ms_bus.ex       = es_ex;
        es_to_ms_bus.exc_code = es_exc_code;
        es_to_ms_bus.bd       = ds_r.bd;
    end

    // bypass to decode
    assign exe_dest   = (es_valid && ds_r.gr_we) ? ds_r.dest : 5'd0;
    assign exe_result = es_valid ? alu_result : '0;
    assign exe_load   = es_valid &&
                        (ds_r.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW});

endmodule

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     kill,
    input  logic                     start,
    input  exe_pkg::alu_op_e         op,
    input  logic [exe_pkg::XLEN-1:0] a,
    input  logic [exe_pkg::XLEN-1:0] b,
    output logic [exe_pkg::XLEN-1:0] hi,
    output logic [exe_pkg::XLEN-1:0] lo,
    output logic                     done
);
    import exe_pkg::*;

    logic              sgn;
    logic              is_div;
    logic [XLEN-1:0]   abs_a;
    logic [XLEN-1:0]   abs_b;
    logic [5:0]        cnt;        // cycles left, zero when idle
    logic              is_div_r;
    logic              neg_lo_r;   // negate product or quotient
    logic              neg_hi_r;   // remainder follows the dividend
    logic [XLEN-1:0]   hi_r;       // remainder / product high
    logic [XLEN-1:0]   lo_r;       // quotient / multiplicand
    logic [XLEN-1:0]   b_r;
    logic [XLEN:0]     rem_shift;
    logic [XLEN+1:0]   trial;
    logic [2*XLEN-1:0] prod;
    logic [2*XLEN-1:0] prod_fix;

    assign sgn    = (op == ALU_MULT) || (op == ALU_DIV);
    assign is_div = (op == ALU_DIV) || (op == ALU_DIVU);
    assign abs_a  = (sgn && a[XLEN-1]) ? -a : a;
    assign abs_b  = (sgn && b[XLEN-1]) ? -b : b;

    // one restoring step: shift in next dividend bit, try to subtract
    assign rem_shift = {hi_r, lo_r[XLEN-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, b_r};
    assign prod      = lo_r * b_r;

    always_ff @(posedge clk) begin
        if (reset || kill) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            cnt  <= is_div ? 6'(DIV_CYCLES - 1) : 6'(MUL_CYCLES - 1);
            done <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 6'd1;
            if (cnt == 6'd1) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div_r <= is_div;
            neg_lo_r <= sgn && (a[XLEN-1] ^ b[XLEN-1]);
            neg_hi_r <= sgn && a[XLEN-1];
            hi_r     <= '0;
            lo_r     <= abs_a;
            b_r      <= abs_b;
        end else if (cnt != '0 && is_div_r) begin
            lo_r <= {lo_r[XLEN-2:0], !trial[XLEN+1]};
            hi_r <= trial[XLEN+1] ? rem_shift[XLEN-1:0] : trial[XLEN-1:0];
        end else if (cnt == 6'd1) begin
            {hi_r, lo_r} <= prod;   // second multiply stage
        end
    end

    // sign fix-up on the way out
    assign prod_fix = neg_lo_r ? -{hi_r, lo_r} : {hi_r, lo_r};
    assign lo = is_div_r ? (neg_lo_r ? -lo_r : lo_r) : prod_fix[XLEN-1:0];
    assign hi = is_div_r ? (neg_hi_r ? -hi_r : hi_r) : prod_fix[2*XLEN-1:XLEN];

endmodule

// File: verilog/store_format.sv
`timescale 1ns/1ps

module store_format (
    input  exe_pkg::mem_op_e         mem_op,
    input  logic [exe_pkg::XLEN-1:0] addr,
    input  logic [exe_pkg::XLEN-1:0] rt_value,
    output logic [3:0]               wen,
    output logic [exe_pkg::XLEN-1:0] wdata,
    output logic                     ades,
    output logic                     adel
);
    import exe_pkg::*;

    logic [1:0] ofs;

    assign ofs = addr[1:0];

    always_comb begin
        wen   = 4'b0000;
        wdata = rt_value;
        case (mem_op)
            MEM_SB: begin
                wdata = {4{rt_value[7:0]}};
                wen   = 4'b0001 << ofs;
            end
            MEM_SH: begin
                wdata = {2{rt_value[15:0]}};
                wen   = ofs[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: wen = 4'b1111;
            MEM_SWL: begin
                // high bytes of rt land at the low end of the word
                wdata = rt_value >> {~ofs, 3'b000};
                wen   = 4'b1111 >> ~ofs;
            end
            MEM_SWR: begin
                wdata = rt_value << {ofs, 3'b000};
                wen   = 4'b1111 << ofs;
            end
            default: wen = 4'b0000;   // loads and non-memory ops
        endcase
    end

    assign ades = ((mem_op == MEM_SH) && ofs[0]) ||
                  ((mem_op == MEM_SW) && (ofs != 2'b00));
    assign adel = ((mem_op == MEM_LH || mem_op == MEM_LHU) && ofs[0]) ||
                  ((mem_op == MEM_LW) && (ofs != 2'b00));

endmodule
